/* hw/arch_regfile.sv */
module arch_regfile import rob_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  retire_t     retire,
    input  logic        retire_fire,
    input  logic [4:0]  rd_addr,
    output logic [31:0] rd_data
);

    logic [31:0] regs [1:31];                 // x1..x31, x0 not stored
    logic        wr_en;

    // Only real destinations write
    assign wr_en = retire_fire && retire.reg_write && (retire.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en) begin
            regs[retire.rd] <= retire.value;
        end
    end

    // x0 always reads zero
    assign rd_data = (rd_addr == 5'd0) ? 32'd0 : regs[rd_addr];

endmodule

/* hw/rob_commit.sv */
module rob_commit import rob_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  retire_t head,
    input  logic    head_valid,
    output logic    head_ready,
    output retire_t retire,
    output logic    retire_valid,
    input  logic    retire_ready
);

    retire_t retire_q;                        // Held retired entry
    logic    valid_q;
    logic    take;                            // Head pops into this stage

    // Free slot or drained this cycle
    assign head_ready = !valid_q || retire_ready;
    assign take       = head_valid && head_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (head_ready) begin
            valid_q <= head_valid;            // Refill or go empty
        end
    end

    // Payload only moves on a pop, so order is kept
    always_ff @(posedge clk) begin
        if (take) begin
            retire_q <= head;
        end
    end

    assign retire       = retire_q;
    assign retire_valid = valid_q;

endmodule

/* hw/rob_core.sv */
module rob_core import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  disp_t                 disp,
    input  logic                  disp_valid,
    output logic                  disp_ready,
    output issue_t                issue,
    output logic                  issue_valid,
    input  cpl_t [NUM_CPL-1:0]    cpl,
    input  br_cpl_t               br_cpl,
    output retire_t               head,
    output logic                  head_valid,
    input  logic                  head_ready,
    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc
);

    rob_entry_t             entries [ROB_DEPTH];  // Circular entry storage
    rob_tag_t               head_ptr;             // Oldest entry
    rob_tag_t               tail_ptr;             // Next free slot
    logic [TAG_W:0]         count;                // Busy entries, 0..ROB_DEPTH
    logic                   full;
    logic                   mispredict;           // Live mispredicting branch this cycle
    logic                   disp_fire;
    logic                   pop;
    rob_tag_t               br_off;               // Branch age relative to head
    logic [ROB_DEPTH-1:0]   flush_mask;           // Entries younger than the branch
    rob_entry_t             head_entry;
    issue_t                 issue_q;
    logic                   issue_valid_q;
    logic                   redirect_valid_q;
    logic [31:0]            redirect_pc_q;

    assign full       = (count == (TAG_W+1)'(ROB_DEPTH));
    assign mispredict = br_cpl.valid && br_cpl.mispredict && entries[br_cpl.tag].busy;

    // No allocation while the tail is being pulled back
    assign disp_ready = !full && !mispredict;
    assign disp_fire  = disp_valid && disp_ready;

    assign head_entry = entries[head_ptr];
    assign head_valid = head_entry.busy && head_entry.ready; // Old ready state only
    assign pop        = head_valid && head_ready;

    assign br_off = br_cpl.tag - head_ptr;

    // Age compare by distance from head, wraps with the pointers
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            flush_mask[i] = mispredict && (rob_tag_t'(rob_tag_t'(i) - head_ptr) > br_off);
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (mispredict) begin
                tail_ptr <= br_cpl.tag + 1'b1;        // Just after the branch
                count    <= (TAG_W+1)'(br_off) + (TAG_W+1)'(1) - (TAG_W+1)'(pop);
            end else begin
                if (disp_fire) begin
                    tail_ptr <= tail_ptr + 1'b1;
                end
                count <= count + (TAG_W+1)'(disp_fire) - (TAG_W+1)'(pop);
            end
        end
    end

    // Entry storage, later writes in this block take priority
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            if (disp_fire) begin
                entries[tail_ptr] <= '{busy: 1'b1, ready: 1'b0,
                                       reg_write: disp.reg_write, rd: disp.rd,
                                       value: 32'd0, pc: disp.pc, store_addr: 8'd0};
            end
            for (int p = 0; p < NUM_CPL; p++) begin
                if (cpl[p].valid && entries[cpl[p].tag].busy) begin // Stale tags ignored
                    entries[cpl[p].tag].value <= cpl[p].value;
                    entries[cpl[p].tag].ready <= 1'b1;
                    if (p == CPL_LOAD) begin
                        entries[cpl[p].tag].store_addr <= cpl[p].store_addr;
                    end
                end
            end
            if (br_cpl.valid && entries[br_cpl.tag].busy) begin
                entries[br_cpl.tag].value <= br_cpl.target; // Target retires as value
                entries[br_cpl.tag].ready <= 1'b1;
            end
            if (pop) begin
                entries[head_ptr].busy <= 1'b0;
            end
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (flush_mask[i]) begin
                    entries[i].busy <= 1'b0;          // Squash younger work
                end
            end
        end
    end

    // Allocation report, one cycle after the entry write
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid_q    <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            issue_valid_q    <= disp_fire;
            redirect_valid_q <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            issue_q <= '{tag: tail_ptr, instr: disp.instr, pc: disp.pc};
        end
        if (mispredict) begin
            redirect_pc_q <= br_cpl.target;
        end
    end

    assign issue          = issue_q;
    assign issue_valid    = issue_valid_q;
    assign redirect_valid = redirect_valid_q;
    assign redirect_pc    = redirect_pc_q;

    assign head = '{rd: head_entry.rd, reg_write: head_entry.reg_write,
                    value: head_entry.value, pc: head_entry.pc,
                    store_addr: head_entry.store_addr};

endmodule

/* hw/rob_dispatch.sv */
module rob_dispatch import rob_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_pc,
    output logic        in_ready,
    output disp_t       disp,
    output logic        disp_valid,
    input  logic        disp_ready
);

    logic [6:0] opcode;                       // Major opcode of the incoming word
    logic       bubble;                       // All-zero word
    logic       accept;                       // Handshake on the input side
    logic       dec_reg_write;
    disp_t      disp_q;                       // Pipeline payload
    logic       valid_q;

    assign opcode = in_instr[6:0];
    assign bubble = (in_instr == 32'd0);

    // Stores and branches have no destination register
    assign dec_reg_write = !((opcode == OPC_STORE) || (opcode == OPC_BRANCH));

    // Room when empty or when the core drains us this cycle
    assign in_ready = !valid_q || disp_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= accept && !bubble;     // Bubble accepted but dropped
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !bubble) begin
            disp_q.instr     <= in_instr;
            disp_q.pc        <= in_pc;
            disp_q.rd        <= in_instr[11:7]; // Destination field
            disp_q.reg_write <= dec_reg_write;
        end
    end

    assign disp       = disp_q;
    assign disp_valid = valid_q;

endmodule

/* hw/rob_pkg.sv */
package rob_pkg;

    localparam int ROB_DEPTH = 16;            // Entries in the reorder buffer
    localparam int TAG_W     = 4;             // log2 of ROB_DEPTH
    localparam int NUM_CPL   = 4;             // ALU, MUL, DIV, LOAD
    localparam int CPL_LOAD  = 3;             // Load port index, carries store_addr

    localparam logic [6:0] OPC_STORE  = 7'b0100011; // RV32 S-type
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // RV32 B-type

    typedef logic [TAG_W-1:0] rob_tag_t;      // Entry index

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [4:0]  rd;                      // instr[11:7]
        logic        reg_write;               // Clear for store and branch
    } disp_t;

    typedef struct packed {
        rob_tag_t    tag;                     // Where the execution side reports back
        logic [31:0] instr;
        logic [31:0] pc;
    } issue_t;

    typedef struct packed {
        logic        valid;                   // One-cycle done strobe
        rob_tag_t    tag;
        logic [31:0] value;
        logic [7:0]  store_addr;              // Load port only
    } cpl_t;

    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] target;                  // Also the retired value
        logic        mispredict;
    } br_cpl_t;

    typedef struct packed {
        logic        busy;                    // Allocated and not yet popped
        logic        ready;                   // Result written
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] value;
        logic [31:0] pc;
        logic [7:0]  store_addr;
    } rob_entry_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] value;
        logic [31:0] pc;
        logic [7:0]  store_addr;
    } retire_t;

endpackage

/* hw/rob_top.sv */
module rob_top import rob_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic [31:0]        in_instr,
    input  logic [31:0]        in_pc,
    output logic               in_ready,
    output issue_t             issue,
    output logic               issue_valid,
    input  cpl_t [NUM_CPL-1:0] cpl,
    input  br_cpl_t            br_cpl,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc,
    output retire_t            retire,
    output logic               retire_valid,
    input  logic               retire_ready,
    input  logic [4:0]         rd_addr,
    output logic [31:0]        rd_data
);

    disp_t   disp;                            // Dispatch to core
    logic    disp_valid;
    logic    disp_ready;
    retire_t head;                            // Core head to commit
    logic    head_valid;
    logic    head_ready;
    logic    retire_fire;                     // Retire handshake completes

    assign retire_fire = retire_valid && retire_ready;

    rob_dispatch i_dispatch (
        .clk, .rst,
        .in_valid, .in_instr, .in_pc, .in_ready,
        .disp, .disp_valid, .disp_ready
    );

    rob_core i_core (
        .clk, .rst,
        .disp, .disp_valid, .disp_ready,
        .issue, .issue_valid,
        .cpl, .br_cpl,
        .head, .head_valid, .head_ready,
        .redirect_valid, .redirect_pc
    );

    rob_commit i_commit (
        .clk, .rst,
        .head, .head_valid, .head_ready,
        .retire, .retire_valid, .retire_ready
    );

    arch_regfile i_regfile (
        .clk, .rst,
        .retire, .retire_fire,
        .rd_addr, .rd_data
    );

endmodule

/* list.f */
hw/rob_pkg.sv
hw/rob_dispatch.sv
hw/rob_core.sv
hw/rob_commit.sv
hw/arch_regfile.sv
hw/rob_top.sv
testbench/tb_rob.sv

/* run.sh */
#!/bin/sh
# Build and run the ROB testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
    --top-module tb_rob \
    -f list.f \
    -o sim_rob
./obj_dir/sim_rob

/* testbench/tb_rob.sv */
module tb_rob import rob_pkg::*; ();

    localparam int TBL_LEN  = 14;             // Stimulus rows
    localparam int SPLIT    = 9;              // First row of the second batch
    localparam int BP_WORDS = 20;             // Words offered under back-pressure
    localparam int PORT_BR  = 4;              // Branch port code in the table
    localparam logic [31:0] SEED = 32'hc04db372;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [2:0]  port;                    // 0..3 plain ports, 4 branch
        logic [31:0] value;
        logic [7:0]  addr;                    // Load address
        logic [31:0] target;
        logic        misp;
    } row_t;

    logic clk = 1'b0;
    logic rst, in_valid, in_ready, issue_valid, redirect_valid, retire_valid, retire_ready;
    logic [31:0] in_instr, in_pc, redirect_pc, rd_data;
    logic [4:0] rd_addr;
    issue_t issue;
    cpl_t [NUM_CPL-1:0] cpl;
    br_cpl_t br_cpl;
    retire_t retire;

    row_t tbl [TBL_LEN];
    row_t recs [$];                           // Dispatched rows of this phase
    retire_t exp_q [$];                       // Reference model, program order
    rob_tag_t iss_tag [$];                    // Tag per dispatched row
    bit done [$];                             // Completion already sent
    logic [31:0] model [32];                  // Expected register file
    logic [31:0] exp_target;
    int redirects;
    int acc;
    int seed_ret;
    row_t r;

    rob_top i_dut (.*);

    always #10 clk = ~clk;

    function automatic retire_t expect_of(input row_t w);
        retire_t e;
        e.rd = w.instr[11:7];
        e.reg_write = !(w.instr[6:0] == 7'b0100011 || w.instr[6:0] == 7'b1100011);
        e.value = (w.port == PORT_BR) ? w.target : w.value; // Branch retires its target
        e.pc = w.pc;
        e.store_addr = (w.port == CPL_LOAD) ? w.addr : 8'd0;
        return e;
    endfunction

    function automatic row_t bp_row(input int k);
        row_t w;
        w.instr = {12'(k), 5'd0, 3'b000, 5'(k % 31 + 1), 7'b0010011}; // addi
        w.pc = 32'h400 + 32'(4 * k);
        w.port = 3'(k % 4);
        w.value = 32'hbeef0000 + 32'(k);
        w.addr = 8'(k * 3);
        w.target = '0;
        w.misp = 1'b0;
        return w;
    endfunction

    task automatic check(input string name, input logic [79:0] got, input logic [79:0] want);
        if (got !== want) begin
            $display("FAILED t=%0t %s got=%0h expected=%0h", $time, name, got, want);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "%s", msg);
    endtask

    // Issue, redirect and retire monitor
    always @(posedge clk) begin
        retire_t e;
        if (!rst) begin
            if (issue_valid) begin
                if (iss_tag.size() >= recs.size()) fail_plain("issue with no instruction pending");
                else begin
                    check("issue.pc", issue.pc, recs[iss_tag.size()].pc);
                    check("issue.instr", issue.instr, recs[iss_tag.size()].instr);
                    iss_tag.push_back(issue.tag);
                end
            end
            if (redirect_valid) begin
                check("redirect_pc", redirect_pc, exp_target);
                redirects++;
            end
            if (retire_valid && retire_ready) begin
                if (exp_q.size() == 0) fail_plain("retire seen with nothing expected");
                else begin
                    e = exp_q.pop_front();
                    check("retire.pc", retire.pc, e.pc);
                    check("retire.rd", retire.rd, e.rd);
                    check("retire.reg_write", retire.reg_write, e.reg_write);
                    check("retire.value", retire.value, e.value);
                    check("retire.store_addr", retire.store_addr, e.store_addr);
                    if (e.reg_write && e.rd != 5'd0) model[e.rd] = e.value;
                end
            end
        end
    end

    task automatic dispatch(input row_t w);
        @(negedge clk);
        in_valid = 1'b1;
        in_instr = w.instr;
        in_pc = w.pc;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);                       // Accepted here
        if (w.instr != 32'd0) begin           // Bubbles leave no trace
            recs.push_back(w);
            done.push_back(1'b0);
            exp_q.push_back(expect_of(w));
        end
    endtask

    task automatic send(input int k);
        row_t w;
        w = recs[k];
        @(negedge clk);
        cpl = '0;
        br_cpl = '0;
        if (w.port == PORT_BR) begin
            br_cpl = '{valid: 1'b1, tag: iss_tag[k], target: w.target, mispredict: w.misp};
            if (w.misp) begin
                exp_target = w.target;
                for (int j = k + 1; j < recs.size(); j++) begin
                    void'(exp_q.pop_back());  // Younger work never retires
                    done[j] = 1'b1;
                end
            end
        end else begin
            cpl[w.port] = '{valid: 1'b1, tag: iss_tag[k], value: w.value, store_addr: w.addr};
        end
        done[k] = 1'b1;
    endtask

    // Random permutation of everything issued and not yet completed
    task automatic complete_issued();
        int idx [$];
        int j;
        int t;
        for (int k = 0; k < iss_tag.size(); k++) if (!done[k]) idx.push_back(k);
        for (int k = idx.size() - 1; k > 0; k--) begin
            j = int'($urandom % (k + 1));
            t = idx[k];
            idx[k] = idx[j];
            idx[j] = t;
        end
        foreach (idx[k]) if (!done[idx[k]]) send(idx[k]);
        @(negedge clk);
        cpl = '0;
        br_cpl = '0;
    endtask

    task automatic wait_issued(input int n);
        while (iss_tag.size() < n) @(posedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);            // Catch stray retires
        recs.delete();
        iss_tag.delete();
        done.delete();
    endtask

    task automatic read_regs();
        for (int i = 0; i < 32; i++) begin
            rd_addr = 5'(i);
            #1;
            check($sformatf("rd_data x%0d", i), rd_data, model[i]);
        end
    endtask

    task automatic run_batch(input int lo, input int hi);
        for (int i = lo; i < hi; i++) dispatch(tbl[i]);
        @(negedge clk);
        in_valid = 1'b0;
        wait_issued(recs.size());
        complete_issued();
        drain();
    endtask

    initial begin
        #(TBL_LEN * 40 * 20);                 // 40 cycles per row
        $display("Watchdog expired before the run finished");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    initial begin
        seed_ret = int'($urandom(SEED));
        rst = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc = '0;
        cpl = '0;
        br_cpl = '0;
        retire_ready = 1'b1;
        rd_addr = '0;
        redirects = 0;
        exp_target = '0;
        foreach (model[i]) model[i] = '0;
        //          instr          pc        port  value          addr    target        misp
        tbl[0]  = '{32'h00100093, 32'h100, 3'd0, 32'h0000000b, 8'h00, 32'h0,   1'b0};
        tbl[1]  = '{32'h00000000, 32'h104, 3'd0, 32'h0,        8'h00, 32'h0,   1'b0};
        tbl[2]  = '{32'h02000133, 32'h108, 3'd1, 32'h00001234, 8'h00, 32'h0,   1'b0};
        tbl[3]  = '{32'h00002183, 32'h10c, 3'd3, 32'hcafe0003, 8'h44, 32'h0,   1'b0};
        tbl[4]  = '{32'h003122a3, 32'h110, 3'd0, 32'h00000777, 8'h00, 32'h0,   1'b0};
        tbl[5]  = '{32'h00208063, 32'h114, 3'd4, 32'h0,        8'h00, 32'h200, 1'b1};
        tbl[6]  = '{32'h02004333, 32'h118, 3'd2, 32'h00006666, 8'h00, 32'h0,   1'b0};
        tbl[7]  = '{32'h00700393, 32'h11c, 3'd0, 32'h00000007, 8'h00, 32'h0,   1'b0};
        tbl[8]  = '{32'h00000000, 32'h120, 3'd0, 32'h0,        8'h00, 32'h0,   1'b0};
        tbl[9]  = '{32'h06300093, 32'h200, 3'd0, 32'h00000063, 8'h00, 32'h0,   1'b0};
        tbl[10] = '{32'h00002483, 32'h204, 3'd3, 32'hd00d0009, 8'h7c, 32'h0,   1'b0};
        tbl[11] = '{32'h02004533, 32'h208, 3'd2, 32'h0000000a, 8'h00, 32'h0,   1'b0};
        tbl[12] = '{32'h020001b3, 32'h20c, 3'd1, 32'h00030003, 8'h00, 32'h0,   1'b0};
        tbl[13] = '{32'h00500013, 32'h210, 3'd0, 32'h00000005, 8'h00, 32'h0,   1'b0}; // x0
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check("issue_valid", issue_valid, 1'b0);
        check("retire_valid", retire_valid, 1'b0);
        check("redirect_valid", redirect_valid, 1'b0);
        check("in_ready", in_ready, 1'b1);
        read_regs();

        run_batch(0, SPLIT);                  // Holds the mispredicting branch
        check("redirect pulses", redirects, 1);
        run_batch(SPLIT, TBL_LEN);            // Fetched from the redirect target
        read_regs();

        @(negedge clk);
        retire_ready = 1'b0;
        acc = 0;
        for (int c = 0; c < BP_WORDS + 8 && acc < BP_WORDS; c++) begin
            @(negedge clk);
            r = bp_row(acc);
            in_valid = 1'b1;
            in_instr = r.instr;
            in_pc = r.pc;
            #1;
            if (in_ready) begin
                @(posedge clk);
                recs.push_back(r);
                done.push_back(1'b0);
                exp_q.push_back(expect_of(r));
                acc++;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        if (acc > ROB_DEPTH + 2 || acc == BP_WORDS) fail_plain("in_ready never fell when full");
        wait_issued(ROB_DEPTH);
        complete_issued();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check("retire_valid", retire_valid, 1'b1);    // Oldest result held in commit
        check("retire.pc", retire.pc, exp_q[0].pc);
        retire_ready = 1'b1;
        wait_issued(acc);
        complete_issued();
        drain();
        read_regs();
        check("redirect pulses", redirects, 1);
        $display("=== PASS ===");
        $finish;
    end

endmodule
